// ==== Makefile ====
# Verilator build and run for the drop FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_drop_fifo
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up as a line of its own
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
source/fifo_pkg.sv
source/drop_pkg.sv
source/counter_bin_load.sv
source/drop_fifo_sync.sv
source/drop_ctrl.sv
source/drop_fifo_top.sv
testbench/drop_fifo_checker.sv
testbench/tb_drop_fifo.sv

// ==== source/counter_bin_load.sv ====
/*
 * Pointer counter for the drop FIFO
 * Counts +1 with the wrap bit toggling after the last index,
 * adds an arbitrary amount with wrap at twice the depth, and
 * loads a new value. Priority is load, then add, then +1
 */
module counter_bin_load
        import fifo_pkg::*;
(
        input  logic clk,
        input  logic rst_n,
        input  logic enable,
        input  logic add_enable,
        input  ptr_t add_value,
        input  logic load,
        input  ptr_t load_value,
        output ptr_t counter_bin_curr,
        output ptr_t counter_bin_next
);

        // Sum one bit wider so the wrap compare sees the carry
        logic [PTR_W:0] sum_ext;

        // --------------------------------------------------
        // Next value
        // --------------------------------------------------
        always_comb begin
                // Hold unless something below says otherwise
                counter_bin_next = counter_bin_curr;
                sum_ext = {1'b0, counter_bin_curr} + {1'b0, add_value};

                if (load) begin
                        // Jump straight to the given pointer
                        counter_bin_next = load_value;
                end else if (add_enable) begin
                        // Add with wrap at twice DEPTH
                        if (sum_ext >= (PTR_W + 1)'(PTR_WRAP)) begin
                                counter_bin_next = ptr_t'(sum_ext - (PTR_W + 1)'(PTR_WRAP));
                        end else begin
                                counter_bin_next = sum_ext[PTR_W-1:0];
                        end
                end else if (enable) begin
                        if (counter_bin_curr[ADDR_W-1:0] == LAST_ADDR) begin
                                // Last index flips the wrap bit and restarts at 0
                                counter_bin_next = {~counter_bin_curr[PTR_W-1], {ADDR_W{1'b0}}};
                        end else begin
                                counter_bin_next = counter_bin_curr + ptr_t'(1);
                        end
                end
        end

        // --------------------------------------------------
        // Register
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        counter_bin_curr <= '0;
                end else begin
                        counter_bin_curr <= counter_bin_next;
                end
        end

        // A +1 step lands one past the old value modulo twice the depth
        a_step_plus_one: assert property (
                @(posedge clk) disable iff (!rst_n)
                (enable && !add_enable && !load) |=>
                        (counter_bin_curr == $past(counter_bin_curr) + ptr_t'(1))
        );

endmodule : counter_bin_load

// ==== source/drop_ctrl.sv ====
/*
 * Drop command server
 * Serves a four-phase req/ack drop command. A request either skips
 * the oldest entries, clamped to the occupancy, or flushes all of
 * them. The number removed is reported with drop_ack
 */
module drop_ctrl
        import fifo_pkg::*;
        import drop_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      drop_req,
        input  drop_cnt_t drop_count,
        input  logic      drop_all,
        output logic      drop_ack,
        output drop_cnt_t drop_dropped,
        input  count_t    fifo_count,
        output logic      skip_apply,
        output drop_cnt_t skip_amount,
        output logic      flush_apply
);

        drop_state_t state;
        drop_state_t state_next;

        // Occupancy seen as a drop amount
        drop_cnt_t avail;
        // Amount that will actually be removed
        drop_cnt_t amount;

        // --------------------------------------------------
        // Amount
        // --------------------------------------------------
        assign avail = drop_cnt_t'(fifo_count);

        always_comb begin
                if (drop_all) begin
                        // Flush removes whatever is stored
                        amount = avail;
                end else if (drop_count > avail) begin
                        amount = avail;
                end else begin
                        amount = drop_count;
                end
        end

        // --------------------------------------------------
        // FSM
        // --------------------------------------------------
        always_comb begin
                state_next = state;
                case (state)
                        IDLE: begin
                                if (drop_req) begin
                                        state_next = APPLY;
                                end
                        end
                        // Exactly one cycle and one pulse here
                        APPLY: state_next = ACK;
                        ACK: begin
                                // Close the handshake once the requester lets go
                                if (!drop_req) begin
                                        state_next = IDLE;
                                end
                        end
                        default: state_next = IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state        <= IDLE;
                        drop_dropped <= '0;
                end else begin
                        state <= state_next;
                        // Report is held through ACK
                        if (state == APPLY) begin
                                drop_dropped <= amount;
                        end
                end
        end

        // Pulses to the core are never high together
        assign skip_apply  = (state == APPLY) & ~drop_all;
        assign flush_apply = (state == APPLY) & drop_all;
        assign skip_amount = amount;

        assign drop_ack = (state == ACK);

        // Ack only answers a live request
        a_ack_needs_req: assert property (
                @(posedge clk) disable iff (!rst_n)
                $rose(drop_ack) |-> drop_req
        );

endmodule : drop_ctrl

// ==== source/drop_fifo_sync.sv ====
/*
 * Drop FIFO storage core
 * Eight-entry synchronous FIFO with first-word-fall-through reads.
 * Besides normal reads the read pointer can skip ahead by a given
 * amount or jump to the write pointer, discarding entries unread
 */
module drop_fifo_sync
        import fifo_pkg::*;
        import drop_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      wr_valid,
        output logic      wr_ready,
        input  data_t     wr_data,
        output logic      rd_valid,
        input  logic      rd_ready,
        output data_t     rd_data,
        input  logic      skip_apply,
        input  drop_cnt_t skip_amount,
        input  logic      flush_apply,
        output count_t    fifo_count
);

        // Pointers with wrap bit
        ptr_t wr_ptr;
        ptr_t rd_ptr;

        // Storage indices
        addr_t wr_addr;
        addr_t rd_addr;

        logic full;
        logic empty;

        // High in the one cycle a skip or flush lands
        logic apply;

        logic wr_xfer;
        logic rd_xfer;

        // Entry storage
        data_t mem [DEPTH];

        // --------------------------------------------------
        // Status
        // --------------------------------------------------
        assign wr_addr = wr_ptr[ADDR_W-1:0];
        assign rd_addr = rd_ptr[ADDR_W-1:0];

        // Same index, different wrap bit
        assign full = (wr_addr == rd_addr) && (wr_ptr[PTR_W-1] != rd_ptr[PTR_W-1]);
        // Same index, same wrap bit
        assign empty = (wr_ptr == rd_ptr);

        // With a power-of-two depth the modular difference is the occupancy
        assign fifo_count = count_t'(wr_ptr - rd_ptr);

        assign apply = skip_apply | flush_apply;

        // --------------------------------------------------
        // Handshakes
        // --------------------------------------------------
        assign wr_ready = ~full;
        // Head is hidden while the read pointer is being moved
        assign rd_valid = ~empty & ~apply;

        assign wr_xfer = wr_valid & wr_ready;
        assign rd_xfer = rd_valid & rd_ready;

        // Fall-through head entry
        assign rd_data = mem[rd_addr];

        always_ff @(posedge clk) begin
                if (wr_xfer) begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // --------------------------------------------------
        // Pointers
        // --------------------------------------------------

        // Write side only ever steps by one
        counter_bin_load u_wr_ptr (
                .clk              (clk),
                .rst_n            (rst_n),
                .enable           (wr_xfer),
                .add_enable       (1'b0),
                .add_value        ('0),
                .load             (1'b0),
                .load_value       ('0),
                .counter_bin_curr (wr_ptr),
                .counter_bin_next ()
        );

        // Read side steps on reads, adds on skip, loads on flush
        // Flush takes the pre-edge write pointer so a same-cycle write survives
        counter_bin_load u_rd_ptr (
                .clk              (clk),
                .rst_n            (rst_n),
                .enable           (rd_xfer),
                .add_enable       (skip_apply),
                .add_value        (ptr_t'(skip_amount)),
                .load             (flush_apply),
                .load_value       (wr_ptr),
                .counter_bin_curr (rd_ptr),
                .counter_bin_next ()
        );

        // --------------------------------------------------
        // Checks
        // --------------------------------------------------

        // A write while full would push the occupancy past the depth
        a_no_write_when_full: assert property (
                @(posedge clk) disable iff (!rst_n)
                int'(fifo_count) <= DEPTH
        );

        // Controller must clamp before the pulse reaches the core
        a_skip_within_count: assert property (
                @(posedge clk) disable iff (!rst_n)
                skip_apply |-> (int'(skip_amount) <= int'(fifo_count))
        );

endmodule : drop_fifo_sync

// ==== source/drop_fifo_top.sv ====
/*
 * Drop FIFO top level
 * Joins the storage core and the drop command server. Stream
 * ports use valid/ready, the drop command uses req/ack
 */
module drop_fifo_top
        import fifo_pkg::*;
        import drop_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        // Write stream
        input  logic      wr_valid,
        output logic      wr_ready,
        input  data_t     wr_data,
        // Read stream
        output logic      rd_valid,
        input  logic      rd_ready,
        output data_t     rd_data,
        // Drop command
        input  logic      drop_req,
        input  drop_cnt_t drop_count,
        input  logic      drop_all,
        output logic      drop_ack,
        output drop_cnt_t drop_dropped
);

        // Controller to core
        logic      skip_apply;
        drop_cnt_t skip_amount;
        logic      flush_apply;

        // Core to controller
        count_t    fifo_count;

        drop_fifo_sync u_fifo (
                .clk         (clk),
                .rst_n       (rst_n),
                .wr_valid    (wr_valid),
                .wr_ready    (wr_ready),
                .wr_data     (wr_data),
                .rd_valid    (rd_valid),
                .rd_ready    (rd_ready),
                .rd_data     (rd_data),
                .skip_apply  (skip_apply),
                .skip_amount (skip_amount),
                .flush_apply (flush_apply),
                .fifo_count  (fifo_count)
        );

        drop_ctrl u_ctrl (
                .clk          (clk),
                .rst_n        (rst_n),
                .drop_req     (drop_req),
                .drop_count   (drop_count),
                .drop_all     (drop_all),
                .drop_ack     (drop_ack),
                .drop_dropped (drop_dropped),
                .fifo_count   (fifo_count),
                .skip_apply   (skip_apply),
                .skip_amount  (skip_amount),
                .flush_apply  (flush_apply)
        );

endmodule : drop_fifo_top

// ==== source/drop_pkg.sv ====
/*
 * Drop command definitions
 * Width of a requested or reported drop amount and the states
 * of the req/ack drop command server
 */
package drop_pkg;

        // --------------------------------------------------
        // Drop amount
        // --------------------------------------------------

        // Wide enough for a full FIFO worth of entries
        localparam int DROP_CNT_W = 4;

        typedef logic [DROP_CNT_W-1:0] drop_cnt_t;

        // --------------------------------------------------
        // Command server FSM
        // --------------------------------------------------

        localparam int STATE_W = 2;

        // IDLE waits for drop_req
        // APPLY issues one skip or flush pulse
        // ACK holds drop_ack until drop_req falls
        typedef enum logic [STATE_W-1:0] {
                IDLE,
                APPLY,
                ACK
        } drop_state_t;

endpackage : drop_pkg

// ==== source/fifo_pkg.sv ====
/*
 * Drop FIFO geometry
 * Entry count, index and pointer widths, and the vector types
 * shared by the pointer counters and the storage core
 */
package fifo_pkg;

        // --------------------------------------------------
        // Geometry
        // --------------------------------------------------

        // Number of stored entries
        localparam int DEPTH = 8;

        // Storage index width
        localparam int ADDR_W = 3;

        // Pointer is the index plus one wrap bit
        localparam int PTR_W = ADDR_W + 1;

        // Payload width of one entry
        localparam int DATA_W = 16;

        // Occupancy runs from 0 to DEPTH inclusive
        localparam int COUNT_W = 4;

        // Add path of a pointer wraps at twice the depth
        localparam int PTR_WRAP = 2 * DEPTH;

        // Highest storage index, where +1 toggles the wrap bit
        localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

        // --------------------------------------------------
        // Vector types
        // --------------------------------------------------

        typedef logic [ADDR_W-1:0]  addr_t;
        typedef logic [PTR_W-1:0]   ptr_t;
        typedef logic [DATA_W-1:0]  data_t;
        typedef logic [COUNT_W-1:0] count_t;

endpackage : fifo_pkg

// ==== testbench/drop_fifo_checker.sv ====
/*
 * Drop FIFO checker
 * Watches the DUT ports and keeps a reference queue of the stored
 * entries. Compares reads, status flags, drop reports and the
 * req/ack timing against that queue
 */
module drop_fifo_checker
        import fifo_pkg::*;
        import drop_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      wr_valid,
        input  logic      wr_ready,
        input  data_t     wr_data,
        input  logic      rd_valid,
        input  logic      rd_ready,
        input  data_t     rd_data,
        input  logic      drop_req,
        input  drop_cnt_t drop_count,
        input  logic      drop_all,
        input  logic      drop_ack,
        input  drop_cnt_t drop_dropped,
        output int        error_count
);

        // Entries the DUT should hold, oldest first
        data_t model_q[$];

        string test_name = "reset";
        int errors = 0;

        // Occupancy at the previous edge that APPLY clamps to
        int size_last;
        // Consecutive edges with drop_req high
        int req_edges;
        logic ack_last;
        logic req_last;

        assign error_count = errors;

        task automatic start_test(input string name);
                test_name = name;
        endtask

        task automatic report_mismatch(input string what, input int expected, input int actual);
                errors++;
                $display("mismatch %s %s: expected 0x%0h, actual 0x%0h",
                         test_name, what, expected, actual);
        endtask

        task automatic report_error(input string msg);
                errors++;
                $display("error in %s: %s", test_name, msg);
        endtask

        always @(posedge clk) begin : watch
                int expect_amount;
                data_t head;
                logic apply_cycle;
                if (!rst_n) begin
                        model_q.delete();
                        size_last = 0;
                        req_edges = 0;
                        ack_last  = 1'b0;
                        req_last  = 1'b0;
                end else begin
                        // --------------------------------------------------
                        // Drop report seen one edge after the pulse landed
                        // --------------------------------------------------
                        if (drop_ack && !ack_last) begin
                                // Two edges of drop_req before the ack shows
                                if (req_edges != 2) begin
                                        report_mismatch("drop_ack delay", 2, req_edges);
                                end
                                if (drop_all) begin
                                        expect_amount = size_last;
                                end else if (int'(drop_count) < size_last) begin
                                        expect_amount = int'(drop_count);
                                end else begin
                                        expect_amount = size_last;
                                end
                                if (int'(drop_dropped) != expect_amount) begin
                                        report_mismatch("drop_dropped", expect_amount,
                                                        int'(drop_dropped));
                                end
                                // Oldest entries go; a write in the apply cycle sits behind them
                                for (int i = 0; i < expect_amount && model_q.size() > 0; i++) begin
                                        head = model_q.pop_front();
                                end
                        end

                        // Ack has to follow the request level
                        if (ack_last && req_last && !drop_ack) begin
                                report_error("drop_ack fell while drop_req was still high");
                        end
                        if (ack_last && !req_last && drop_ack) begin
                                report_error("drop_ack still high one cycle after drop_req fell");
                        end

                        // --------------------------------------------------
                        // Status flags
                        // --------------------------------------------------
                        // Head is hidden only in the apply cycle of a request
                        apply_cycle = drop_req && !drop_ack && (req_edges == 1);
                        if (rd_valid !== ((model_q.size() != 0) && !apply_cycle)) begin
                                report_mismatch("rd_valid",
                                                int'((model_q.size() != 0) && !apply_cycle),
                                                int'(rd_valid));
                        end
                        if (wr_ready !== (model_q.size() < DEPTH)) begin
                                report_mismatch("wr_ready", int'(model_q.size() < DEPTH),
                                                int'(wr_ready));
                        end
                        size_last = model_q.size();

                        // --------------------------------------------------
                        // Transfers
                        // --------------------------------------------------
                        if (rd_valid && rd_ready) begin
                                if (model_q.size() == 0) begin
                                        report_error("read transfer while nothing was stored");
                                end else begin
                                        head = model_q.pop_front();
                                        if (rd_data !== head) begin
                                                report_mismatch("rd_data", int'(head),
                                                                int'(rd_data));
                                        end
                                end
                        end
                        if (wr_valid && wr_ready) begin
                                model_q.push_back(wr_data);
                        end

                        ack_last  = drop_ack;
                        req_last  = drop_req;
                        req_edges = drop_req ? req_edges + 1 : 0;
                end
        end

endmodule : drop_fifo_checker

// ==== testbench/tb_drop_fifo.sv ====
/*
 * Drop FIFO testbench
 * Applies a table of write, read, mixed, skip and flush rows to the
 * drop FIFO, prints one line per row and a closing summary
 */
module tb_drop_fifo
        import fifo_pkg::*;
        import drop_pkg::*;
();

        // Row operations
        localparam int OP_WRITE = 0;
        localparam int OP_READ  = 1;
        localparam int OP_MIXED = 2;
        localparam int OP_SKIP  = 3;
        localparam int OP_FLUSH = 4;

        localparam int RESET_CYCLES = 8;
        // Cycles allowed for each ack edge
        localparam int ACK_WAIT     = 16;
        // Extra cycles drop_req stays up after the ack
        localparam int HOLD_CYCLES  = 3;

        logic      clk;
        logic      rst_n;
        logic      wr_valid;
        logic      wr_ready;
        data_t     wr_data;
        logic      rd_valid;
        logic      rd_ready;
        data_t     rd_data;
        logic      drop_req;
        drop_cnt_t drop_count;
        logic      drop_all;
        logic      drop_ack;
        drop_cnt_t drop_dropped;
        int        check_errors;

        // Stimulus table with one entry per row
        string      row_name[$];
        int         row_op[$];
        int         row_len[$];
        logic [7:0] row_rdy[$];

        logic [31:0] rng_state = 32'h18ef55bd;
        int cycle_count = 0;
        int timeout_limit = 0;

        drop_fifo_top drop_fifo_top_inst (
                .clk          (clk),
                .rst_n        (rst_n),
                .wr_valid     (wr_valid),
                .wr_ready     (wr_ready),
                .wr_data      (wr_data),
                .rd_valid     (rd_valid),
                .rd_ready     (rd_ready),
                .rd_data      (rd_data),
                .drop_req     (drop_req),
                .drop_count   (drop_count),
                .drop_all     (drop_all),
                .drop_ack     (drop_ack),
                .drop_dropped (drop_dropped)
        );

        drop_fifo_checker drop_fifo_checker_inst (
                .clk          (clk),
                .rst_n        (rst_n),
                .wr_valid     (wr_valid),
                .wr_ready     (wr_ready),
                .wr_data      (wr_data),
                .rd_valid     (rd_valid),
                .rd_ready     (rd_ready),
                .rd_data      (rd_data),
                .drop_req     (drop_req),
                .drop_count   (drop_count),
                .drop_all     (drop_all),
                .drop_ack     (drop_ack),
                .drop_dropped (drop_dropped),
                .error_count  (check_errors)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        task automatic add_row(input string name, input int op, input int len,
                               input logic [7:0] rdy);
                row_name.push_back(name);
                row_op.push_back(op);
                row_len.push_back(len);
                row_rdy.push_back(rdy);
        endtask

        // Set one cycle of inputs, then wait to just past the next edge
        task automatic step_cycle(input logic wr_on, input logic rd_on);
                wr_valid = wr_on;
                if (wr_on) begin
                        rng_state = xorshift32(rng_state);
                        wr_data = rng_state[DATA_W-1:0];
                end
                rd_ready = rd_on;
                @(posedge clk);
                #1;
        endtask

        task automatic run_burst(input int op, input int len, input logic [7:0] rdy);
                for (int i = 0; i < len; i++) begin
                        step_cycle(op != OP_READ, rdy[i % 8]);
                end
        endtask

        // All four req/ack phases; flush rows keep writing through the window
        task automatic run_drop(input string name, input logic all, input int count,
                                output int fails);
                int waited;
                fails = 0;
                drop_req = 1'b1;
                drop_count = drop_cnt_t'(count);
                drop_all = all;
                waited = 0;
                while (drop_ack !== 1'b1 && waited < ACK_WAIT) begin
                        step_cycle(all, 1'b0);
                        waited++;
                end
                if (drop_ack !== 1'b1) begin
                        $display("error in %s: drop_ack never rose after drop_req", name);
                        fails++;
                end
                for (int i = 0; i < HOLD_CYCLES; i++) begin
                        step_cycle(all, 1'b0);
                end
                drop_req = 1'b0;
                waited = 0;
                while (drop_ack !== 1'b0 && waited < ACK_WAIT) begin
                        step_cycle(all, 1'b0);
                        waited++;
                end
                if (drop_ack !== 1'b0) begin
                        $display("error in %s: drop_ack stayed high after drop_req fell", name);
                        fails++;
                end
                drop_count = '0;
                drop_all = 1'b0;
                wr_valid = 1'b0;
        endtask

        // --------------------------------------------------
        // Watchdog
        // --------------------------------------------------
        initial begin : watchdog
                while (timeout_limit == 0 || cycle_count < timeout_limit) begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("timeout: run still going after %0d cycles", cycle_count);
                $display("tests failed");
                $finish;
        end

        // --------------------------------------------------
        // Driver
        // --------------------------------------------------
        initial begin : driver
                int errs_before;
                int row_fail;
                int passed;
                int failed;
                int len_sum;
                rst_n = 1'b0;
                wr_valid = 1'b0;
                wr_data = '0;
                rd_ready = 1'b0;
                drop_req = 1'b0;
                drop_count = '0;
                drop_all = 1'b0;
                passed = 0;
                failed = 0;
                len_sum = 0;

                add_row("fill_past_full",    OP_WRITE, 10, 8'h00);
                add_row("drain_all",         OP_READ,  10, 8'hff);
                add_row("mixed_wrap",        OP_MIXED, 40, 8'b1011_0110);
                add_row("mixed_backpressure", OP_MIXED, 30, 8'b0010_0100);
                add_row("drain_before_skip", OP_READ,  12, 8'hff);
                add_row("write_six",         OP_WRITE, 6,  8'h00);
                add_row("skip_three",        OP_SKIP,  3,  8'h00);
                add_row("read_after_skip",   OP_READ,  5,  8'hff);
                add_row("write_two",         OP_WRITE, 2,  8'h00);
                add_row("skip_clamped",      OP_SKIP,  7,  8'h00);
                add_row("write_five",        OP_WRITE, 5,  8'h00);
                add_row("flush_with_write",  OP_FLUSH, 0,  8'h00);
                add_row("read_after_flush",  OP_READ,  8,  8'hff);
                add_row("mixed_final",       OP_MIXED, 24, 8'b1101_1011);
                add_row("final_drain",       OP_READ,  12, 8'hff);

                foreach (row_len[r]) begin
                        len_sum += row_len[r];
                end
                timeout_limit = len_sum * 4 + 200;

                repeat (RESET_CYCLES) @(posedge clk);
                #1;
                rst_n = 1'b1;

                for (int r = 0; r < row_name.size(); r++) begin
                        drop_fifo_checker_inst.start_test(row_name[r]);
                        errs_before = check_errors;
                        row_fail = 0;
                        if (row_op[r] == OP_SKIP) begin
                                run_drop(row_name[r], 1'b0, row_len[r], row_fail);
                        end else if (row_op[r] == OP_FLUSH) begin
                                run_drop(row_name[r], 1'b1, 0, row_fail);
                        end else begin
                                run_burst(row_op[r], row_len[r], row_rdy[r]);
                        end
                        // Idle cycle so the checker sees the row's last edge
                        step_cycle(1'b0, 1'b0);
                        row_fail += check_errors - errs_before;
                        if (row_fail == 0) begin
                                passed++;
                                $display("PASS %s", row_name[r]);
                        end else begin
                                failed++;
                                $display("FAIL %s with %0d errors", row_name[r], row_fail);
                        end
                end

                $display("summary: %0d tests run, %0d passed, %0d failed",
                         passed + failed, passed, failed);
                if (failed == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

endmodule : tb_drop_fifo
